//--- logic/pistorm_pkg.sv
package pistorm_pkg;

	// one word on the pi gpio data bus
	typedef logic [15:0] pi_word_t;

	// register select from pi gpio 3..2
	typedef logic [1:0] pi_reg_t;

	localparam pi_reg_t REG_DATA    = 2'd0;
	localparam pi_reg_t REG_ADDR_LO = 2'd1;
	localparam pi_reg_t REG_ADDR_HI = 2'd2;
	localparam pi_reg_t REG_STATUS  = 2'd3;

	// byte address, bit 0 only selects the data strobe lane
	typedef logic [23:0] m68k_addr_t;

	// function code, cpu space is what an idle bus shows
	typedef logic [2:0] fc_t;

	localparam fc_t FC_CPU_SPACE = 3'd7;

	// interrupt priority level
	typedef logic [2:0] ipl_t;

	// 68000 bus cycle states, s0 is idle
	typedef enum logic [2:0] {
		S0,
		S1,
		S2,
		S3,
		S4,
		S5,
		S6,
		S7
	} bus_state_t;

	// e clock phase, ten c8m periods per e period
	typedef logic [3:0] e_count_t;

	localparam e_count_t E_LAST       = 4'd9;
	localparam e_count_t E_HIGH_FIRST = 4'd6;
	localparam e_count_t E_VMA_ASSERT = 4'd2;
	localparam e_count_t E_VMA_DONE   = 4'd8;

	// field positions in the address high register
	localparam int ADDR_HI_A_MSB  = 7;
	localparam int ADDR_HI_SIZE   = 8;
	localparam int ADDR_HI_DIR    = 9;
	localparam int ADDR_HI_FC_MSB = 15;
	localparam int ADDR_HI_FC_LSB = 13;

endpackage

//--- logic/pi_port.sv
`timescale 1ns/10ps

module pi_port import pistorm_pkg::*; #(
	parameter logic [10:0] fw_rev = 11'h001,
	parameter int unsigned sync_stages = 2
) (
	input  logic       c8m,
	input  logic       s0rst,
	input  pi_reg_t    pi_a,
	input  logic       pi_rd,
	input  logic       pi_wr,
	input  pi_word_t   pi_d_in,
	output pi_word_t   pi_d_out,
	output logic       pi_d_oe,
	input  ipl_t       m68k_ipl_n,
	input  logic       m68k_reset_n,
	input  pi_word_t   rd_data,
	output logic       bus_reset,
	output logic       txn_start,
	output m68k_addr_t op_addr,
	output logic       op_byte,
	output logic       op_read,
	output fc_t        op_fc,
	output pi_word_t   wr_data,
	output logic       reset_drive,
	output logic       halt_drive
);

	// synchronizer word is {pi_wr, pi_rd, ipl_n, reset_n}
	// idle values: strobes low, no interrupt, bus not in reset
	localparam logic [5:0] SYNC_IDLE = 6'b00_111_1;

	logic [5:0] sync_q [sync_stages];
	logic [5:0] sync_out;
	logic       wr_s;
	logic       rd_s;
	ipl_t       ipl_n_s;
	logic       wr_q;
	logic       wr_edge;
	pi_word_t   status_word;

	// plain flop chain, depth set from the top level
	always_ff @(posedge c8m or posedge s0rst) begin
		if (s0rst) begin
			for (int i = 0; i < sync_stages; i++) begin
				sync_q[i] <= SYNC_IDLE;
			end
		end else begin
			sync_q[0] <= {pi_wr, pi_rd, m68k_ipl_n, m68k_reset_n};
			for (int i = 1; i < sync_stages; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	assign sync_out  = sync_q[sync_stages-1];
	assign wr_s      = sync_out[5];
	assign rd_s      = sync_out[4];
	assign ipl_n_s   = sync_out[3:1];
	// low while the 68000 bus is held in reset
	assign bus_reset = sync_out[0];

	// act once per write strobe, on its synchronized rising edge
	always_ff @(posedge c8m or posedge s0rst) begin
		if (s0rst) begin
			wr_q <= 1'b0;
		end else begin
			wr_q <= wr_s;
		end
	end

	assign wr_edge = wr_s & ~wr_q;

	// address high write kicks off one bus cycle
	always_ff @(posedge c8m or posedge s0rst) begin
		if (s0rst) begin
			txn_start <= 1'b0;
		end else begin
			txn_start <= wr_edge && (pi_a == REG_ADDR_HI);
		end
	end

	// status write drives the bus reset and halt lines
	always_ff @(posedge c8m or posedge s0rst) begin
		if (s0rst) begin
			reset_drive <= 1'b0;
			halt_drive  <= 1'b0;
		end else if (wr_edge && (pi_a == REG_STATUS)) begin
			reset_drive <= pi_d_in[1];
			halt_drive  <= pi_d_in[0];
		end
	end

	// operation registers, pi_a and pi_d_in are stable for the whole strobe
	always_ff @(posedge c8m) begin
		if (wr_edge) begin
			case (pi_a)
				REG_DATA: begin
					wr_data <= pi_d_in;
				end
				REG_ADDR_LO: begin
					op_addr[15:0] <= pi_d_in;
				end
				REG_ADDR_HI: begin
					op_addr[23:16] <= pi_d_in[ADDR_HI_A_MSB:0];
					op_byte        <= pi_d_in[ADDR_HI_SIZE];
					op_read        <= pi_d_in[ADDR_HI_DIR];
					op_fc          <= pi_d_in[ADDR_HI_FC_MSB:ADDR_HI_FC_LSB];
				end
				default: begin
					// status handled with the control bits
				end
			endcase
		end
	end

	// ipl, firmware revision, bus reset state
	assign status_word = {~ipl_n_s, fw_rev, ~bus_reset, 1'b0};

	// host samples a few cycles after raising pi_rd
	assign pi_d_oe  = rd_s;
	assign pi_d_out = (pi_a == REG_STATUS) ? status_word : rd_data;

endmodule

//--- logic/bus_cycle_fsm.sv
`timescale 1ns/10ps

module bus_cycle_fsm import pistorm_pkg::*; (
	input  logic       c8m,
	input  logic       s0rst,
	input  logic       txn_start,
	input  logic       bus_reset,
	input  logic       dtack_n,
	input  logic       berr_n,
	input  logic       vma_done,
	input  pi_word_t   m68k_d_in,
	output bus_state_t state,
	output logic       txn_in_progress,
	output pi_word_t   rd_data
);

	logic [1:0] dtack_q;
	logic [1:0] berr_q;
	logic       term;
	bus_state_t state_next;

	// two flop synchronizers for the termination inputs
	always_ff @(posedge c8m or posedge s0rst) begin
		if (s0rst) begin
			dtack_q <= 2'b11;
			berr_q  <= 2'b11;
		end else begin
			dtack_q <= {dtack_q[0], dtack_n};
			berr_q  <= {berr_q[0], berr_n};
		end
	end

	// s4 ends on dtack, bus error or a finished vpa/vma transfer
	assign term = ~dtack_q[1] | ~berr_q[1] | vma_done;

	always_comb begin
		state_next = state;
		case (state)
			S0: begin
				// a start outside s0 is dropped
				if (txn_start) begin
					state_next = S1;
				end
			end
			S1: state_next = S2;
			S2: state_next = S3;
			S3: state_next = S4;
			S4: begin
				// wait states
				if (term) begin
					state_next = S5;
				end
			end
			S5: state_next = S6;
			S6: state_next = S7;
			S7: state_next = S0;
			default: state_next = S0;
		endcase
		// bus reset aborts whatever is running
		if (!bus_reset) begin
			state_next = S0;
		end
	end

	always_ff @(posedge c8m or posedge s0rst) begin
		if (s0rst) begin
			state           <= S0;
			txn_in_progress <= 1'b0;
		end else begin
			state           <= state_next;
			// busy from s1 entry until s7 is left
			txn_in_progress <= (state_next != S0);
		end
	end

	// latch the bus data as s6 begins
	always_ff @(posedge c8m) begin
		if ((state == S5) && (state_next == S6)) begin
			rd_data <= m68k_d_in;
		end
	end

endmodule

//--- logic/e_clock_vma.sv
`timescale 1ns/10ps

module e_clock_vma import pistorm_pkg::*; (
	input  logic       c8m,
	input  logic       s0rst,
	input  bus_state_t state,
	input  logic       vpa_n,
	output logic       e,
	output logic       vma_n,
	output logic       vma_done
);

	e_count_t   e_cnt;
	logic [1:0] vpa_q;

	// free running 0..9, six low and four high
	always_ff @(posedge c8m or posedge s0rst) begin
		if (s0rst) begin
			e_cnt <= '0;
		end else if (e_cnt == E_LAST) begin
			e_cnt <= '0;
		end else begin
			e_cnt <= e_cnt + 4'd1;
		end
	end

	assign e = (e_cnt >= E_HIGH_FIRST);

	always_ff @(posedge c8m or posedge s0rst) begin
		if (s0rst) begin
			vpa_q <= 2'b11;
		end else begin
			vpa_q <= {vpa_q[0], vpa_n};
		end
	end

	// vma asserts early in the e low phase so the peripheral sees a full e high
	always_ff @(posedge c8m or posedge s0rst) begin
		if (s0rst) begin
			vma_n <= 1'b1;
		end else if ((state == S7) || (state == S0)) begin
			// s0 covers a cycle cut short by bus reset
			vma_n <= 1'b1;
		end else if ((state == S4) && !vpa_q[1] && (e_cnt == E_VMA_ASSERT)) begin
			vma_n <= 1'b0;
		end
	end

	// transfer completes late in e high
	assign vma_done = ~vma_n & (e_cnt == E_VMA_DONE);

endmodule

//--- logic/m68k_bus_out.sv
`timescale 1ns/10ps

module m68k_bus_out import pistorm_pkg::*; (
	input  logic        c8m,
	input  logic        s0rst,
	input  bus_state_t  state,
	input  m68k_addr_t  op_addr,
	input  logic        op_byte,
	input  logic        op_read,
	input  fc_t         op_fc,
	input  pi_word_t    wr_data,
	output logic [22:0] a,
	output logic        a_oe,
	output pi_word_t    d_out,
	output logic        d_oe,
	output fc_t         fc,
	output logic        as_n,
	output logic        uds_n,
	output logic        lds_n,
	output logic        rw
);

	logic s1_7;
	logic s2_6;
	logic s2_7;
	logic s3_7;
	logic s4_6;
	logic strobe_on;
	logic uds_val;
	logic lds_val;

	// state windows
	assign s1_7 = (state != S0);
	assign s2_6 = (state >= S2) && (state <= S6);
	assign s2_7 = (state >= S2);
	assign s3_7 = (state >= S3);
	assign s4_6 = (state >= S4) && (state <= S6);

	// writes hold the data strobes back until the data is on the bus
	assign strobe_on = op_read ? s2_6 : s4_6;

	// word: both lanes, byte: even address is the upper lane
	assign uds_val = op_byte & op_addr[0];
	assign lds_val = op_byte & ~op_addr[0];

	// all drive outputs lag the state by one clock
	always_ff @(posedge c8m or posedge s0rst) begin
		if (s0rst) begin
			as_n  <= 1'b1;
			uds_n <= 1'b1;
			lds_n <= 1'b1;
			rw    <= 1'b1;
			fc    <= FC_CPU_SPACE;
			a_oe  <= 1'b0;
			d_oe  <= 1'b0;
		end else begin
			as_n  <= ~s2_6;
			uds_n <= strobe_on ? uds_val : 1'b1;
			lds_n <= strobe_on ? lds_val : 1'b1;
			rw    <= s2_7 ? op_read : 1'b1;
			fc    <= s1_7 ? op_fc : FC_CPU_SPACE;
			a_oe  <= s1_7;
			d_oe  <= s3_7 & ~op_read;
		end
	end

	// address and data stand in for the old 373/374 latches
	always_ff @(posedge c8m) begin
		a     <= op_addr[23:1];
		d_out <= wr_data;
	end

endmodule

//--- logic/pistorm_bridge.sv
`timescale 1ns/10ps

module pistorm_bridge import pistorm_pkg::*; #(
	parameter logic [10:0] fw_rev = 11'h001,
	parameter int unsigned sync_stages = 2
) (
	input  logic        c8m,
	input  logic        s0rst,
	// pi gpio side
	input  pi_reg_t     pi_a,
	input  logic        pi_rd,
	input  logic        pi_wr,
	input  pi_word_t    pi_d_in,
	output pi_word_t    pi_d_out,
	output logic        pi_d_oe,
	output logic        pi_txn_in_progress,
	output logic        pi_berr,
	// 68000 bus side
	output logic [22:0] a,
	output logic        a_oe,
	output pi_word_t    d_out,
	output logic        d_oe,
	output fc_t         fc,
	output logic        as_n,
	output logic        uds_n,
	output logic        lds_n,
	output logic        rw,
	output logic        e,
	output logic        vma_n,
	input  pi_word_t    m68k_d_in,
	input  logic        dtack_n,
	input  logic        berr_n,
	input  logic        vpa_n,
	input  ipl_t        m68k_ipl_n,
	input  logic        m68k_reset_n,
	output logic        reset_drive,
	output logic        halt_drive
);

	logic       bus_reset;
	logic       txn_start;
	m68k_addr_t op_addr;
	logic       op_byte;
	logic       op_read;
	fc_t        op_fc;
	pi_word_t   wr_data;
	pi_word_t   rd_data;
	bus_state_t state;
	logic       vma_done;

	// pi samples berr directly after the cycle ends
	assign pi_berr = berr_n;

	pi_port #(
		.fw_rev      (fw_rev),
		.sync_stages (sync_stages)
	) i_pi_port (
		.c8m          (c8m),
		.s0rst        (s0rst),
		.pi_a         (pi_a),
		.pi_rd        (pi_rd),
		.pi_wr        (pi_wr),
		.pi_d_in      (pi_d_in),
		.pi_d_out     (pi_d_out),
		.pi_d_oe      (pi_d_oe),
		.m68k_ipl_n   (m68k_ipl_n),
		.m68k_reset_n (m68k_reset_n),
		.rd_data      (rd_data),
		.bus_reset    (bus_reset),
		.txn_start    (txn_start),
		.op_addr      (op_addr),
		.op_byte      (op_byte),
		.op_read      (op_read),
		.op_fc        (op_fc),
		.wr_data      (wr_data),
		.reset_drive  (reset_drive),
		.halt_drive   (halt_drive)
	);

	bus_cycle_fsm i_bus_cycle_fsm (
		.c8m             (c8m),
		.s0rst           (s0rst),
		.txn_start       (txn_start),
		.bus_reset       (bus_reset),
		.dtack_n         (dtack_n),
		.berr_n          (berr_n),
		.vma_done        (vma_done),
		.m68k_d_in       (m68k_d_in),
		.state           (state),
		.txn_in_progress (pi_txn_in_progress),
		.rd_data         (rd_data)
	);

	e_clock_vma i_e_clock_vma (
		.c8m      (c8m),
		.s0rst    (s0rst),
		.state    (state),
		.vpa_n    (vpa_n),
		.e        (e),
		.vma_n    (vma_n),
		.vma_done (vma_done)
	);

	m68k_bus_out i_m68k_bus_out (
		.c8m     (c8m),
		.s0rst   (s0rst),
		.state   (state),
		.op_addr (op_addr),
		.op_byte (op_byte),
		.op_read (op_read),
		.op_fc   (op_fc),
		.wr_data (wr_data),
		.a       (a),
		.a_oe    (a_oe),
		.d_out   (d_out),
		.d_oe    (d_oe),
		.fc      (fc),
		.as_n    (as_n),
		.uds_n   (uds_n),
		.lds_n   (lds_n),
		.rw      (rw)
	);

endmodule

//--- dv/tb_bus_tasks.svh
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

	// called on a falling edge, returns on one
	task automatic pi_write(input pi_reg_t sel, input pi_word_t data);
		case (sel)
			REG_DATA:    shadow_data = data;
			REG_ADDR_LO: shadow_addr_lo = data;
			REG_ADDR_HI: shadow_addr_hi = data;
			default:     shadow_status = data;
		endcase
		pi_a    = sel;
		pi_d_in = data;
		pi_wr   = 1'b1;
		repeat (5) @(negedge c8m);
		pi_wr = 1'b0;
		repeat (5) @(negedge c8m);
	endtask

	// data is valid at the 4th cycle after pi_rd rises
	task automatic pi_read(input pi_reg_t sel, output pi_word_t data);
		pi_a  = sel;
		pi_rd = 1'b1;
		repeat (4) @(negedge c8m);
		check_eq(32'(pi_d_oe), 32'd1, "pi_d_oe during read");
		data  = pi_d_out;
		pi_rd = 1'b0;
		repeat (4) @(negedge c8m);
	endtask

	// address high write, then wait for the cycle to start and end
	task automatic start_cycle(input pi_word_t hi);
		int rises_before;
		rises_before = txn_rises;
		pi_write(REG_ADDR_HI, hi);
		while ((txn_rises == rises_before) || pi_txn_in_progress) begin
			@(negedge c8m);
		end
		// drive outputs lag the state by one clock
		@(negedge c8m);
		check_bus_idle();
	endtask

	// responsive 68000 slave, one termination per as_n low period
	task automatic bus_slave();
		int wait_cyc;
		dtack_n   = 1'b1;
		berr_n    = 1'b1;
		vpa_n     = 1'b1;
		m68k_d_in = '0;
		forever begin
			@(negedge c8m);
			if (!s0rst && !as_n) begin
				if (force_mode == MODE_RANDOM) begin
					cyc_mode = int'($urandom_range(2, 0));
				end else begin
					cyc_mode = force_mode;
				end
				wait_cyc   = int'($urandom_range(6, 0));
				slave_data = 16'($urandom);
				seen_vma   = 1'b0;
				repeat (wait_cyc) @(negedge c8m);
				m68k_d_in = slave_data;
				case (cyc_mode)
					MODE_DTACK: dtack_n = 1'b0;
					MODE_BERR:  berr_n = 1'b0;
					MODE_VPA:   vpa_n = 1'b0;
					default: begin
						// no answer, only a bus reset ends this one
					end
				endcase
				// last sample is the one just before as_n rises
				while (!as_n) begin
					seen.a     = a;
					seen.fc    = fc;
					seen.rw    = rw;
					seen.uds_n = uds_n;
					seen.lds_n = lds_n;
					seen.d_oe  = d_oe;
					seen.data  = d_out;
					seen_berr  = pi_berr;
					if (!vma_n) begin
						seen_vma = 1'b1;
					end
					@(negedge c8m);
				end
				dtack_n = 1'b1;
				berr_n  = 1'b1;
				vpa_n   = 1'b1;
			end
		end
	endtask

`endif

//--- dv/tb_pistorm_bridge.sv
`timescale 1ns/10ps

module tb_pistorm_bridge import pistorm_pkg::*; ();

	localparam logic [10:0] FW_REV = 11'h2a5;
	localparam int HALF_PERIOD = 50;
	localparam logic [31:0] SEED = 32'hd699;
	// pi register accesses plus bus cycles in the sequence below
	localparam int N_TXN = 48;
	localparam int WATCHDOG_CYCLES = 60 * N_TXN + 200;
	localparam int N_COMPARED = 10;

	// slave termination modes
	localparam int MODE_RANDOM = -1;
	localparam int MODE_DTACK  = 0;
	localparam int MODE_BERR   = 1;
	localparam int MODE_VPA    = 2;
	localparam int MODE_HANG   = 3;

	// what the bus shows while as_n is low
	typedef struct packed {
		logic [22:0] a;
		fc_t         fc;
		logic        rw;
		logic        uds_n;
		logic        lds_n;
		logic        d_oe;
		pi_word_t    data;
	} cycle_t;

	logic        c8m;
	logic        s0rst;
	pi_reg_t     pi_a;
	logic        pi_rd;
	logic        pi_wr;
	pi_word_t    pi_d_in;
	pi_word_t    pi_d_out;
	logic        pi_d_oe;
	logic        pi_txn_in_progress;
	logic        pi_berr;
	logic [22:0] a;
	logic        a_oe;
	pi_word_t    d_out;
	logic        d_oe;
	fc_t         fc;
	logic        as_n;
	logic        uds_n;
	logic        lds_n;
	logic        rw;
	logic        e;
	logic        vma_n;
	pi_word_t    m68k_d_in;
	logic        dtack_n;
	logic        berr_n;
	logic        vpa_n;
	ipl_t        m68k_ipl_n;
	logic        m68k_reset_n;
	logic        reset_drive;
	logic        halt_drive;

	// host side copies of the registers as written
	pi_word_t shadow_data;
	pi_word_t shadow_addr_lo;
	pi_word_t shadow_addr_hi;
	pi_word_t shadow_status;

	// slave model record
	int       force_mode = MODE_RANDOM;
	int       cyc_mode = MODE_DTACK;
	pi_word_t slave_data;
	cycle_t   seen;
	logic     seen_berr;
	logic     seen_vma;

	logic abort_expected = 1'b0;
	logic txn_q;
	int   txn_rises = 0;
	int   cycles_checked = 0;
	logic e_q;
	int   e_period_cnt;
	int   e_high_cnt;
	int   e_rises;
	logic vma_q = 1'b1;

	pistorm_bridge #(
		.fw_rev      (FW_REV),
		.sync_stages (2)
	) i_dut (
		.c8m                (c8m),
		.s0rst              (s0rst),
		.pi_a               (pi_a),
		.pi_rd              (pi_rd),
		.pi_wr              (pi_wr),
		.pi_d_in            (pi_d_in),
		.pi_d_out           (pi_d_out),
		.pi_d_oe            (pi_d_oe),
		.pi_txn_in_progress (pi_txn_in_progress),
		.pi_berr            (pi_berr),
		.a                  (a),
		.a_oe               (a_oe),
		.d_out              (d_out),
		.d_oe               (d_oe),
		.fc                 (fc),
		.as_n               (as_n),
		.uds_n              (uds_n),
		.lds_n              (lds_n),
		.rw                 (rw),
		.e                  (e),
		.vma_n              (vma_n),
		.m68k_d_in          (m68k_d_in),
		.dtack_n            (dtack_n),
		.berr_n             (berr_n),
		.vpa_n              (vpa_n),
		.m68k_ipl_n         (m68k_ipl_n),
		.m68k_reset_n       (m68k_reset_n),
		.reset_drive        (reset_drive),
		.halt_drive         (halt_drive)
	);

	task automatic check_eq(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		if (got !== expected) begin
			$display("error at %0t: %s, got %0h expected %0h", $time, what, got, expected);
			$display("=== FAIL ===");
			$fatal(1, "mismatch");
		end
	endtask

	// idle bus: strobes high, cpu space, nothing driven
	task automatic check_bus_idle();
		check_eq(32'(as_n), 32'd1, "as_n idle");
		check_eq(32'(uds_n), 32'd1, "uds_n idle");
		check_eq(32'(lds_n), 32'd1, "lds_n idle");
		check_eq(32'(rw), 32'd1, "rw idle");
		check_eq(32'(fc), 32'(FC_CPU_SPACE), "fc idle");
		check_eq(32'(a_oe), 32'd0, "a_oe idle");
		check_eq(32'(d_oe), 32'd0, "d_oe idle");
		check_eq(32'(vma_n), 32'd1, "vma_n idle");
		check_eq(32'(pi_txn_in_progress), 32'd0, "txn_in_progress idle");
	endtask

`include "tb_bus_tasks.svh"

	// status layout: inverted ipl, firmware revision, inverted bus reset, zero
	function automatic pi_word_t expect_status(input ipl_t ipl_n, input logic reset_n);
		return {~ipl_n, FW_REV, ~reset_n, 1'b0};
	endfunction

	function automatic pi_word_t addr_hi_word(input logic [7:0] a_hi, input logic byte_op,
			input logic read, input fc_t f);
		return {f, 3'b000, read, byte_op, a_hi};
	endfunction

	// bus view of one cycle from the pi register contents
	function automatic cycle_t expect_cycle(input pi_word_t lo, input pi_word_t hi,
			input pi_word_t wdata);
		cycle_t c;
		logic   byte_op;
		byte_op = hi[8];
		c.a     = {hi[7:0], lo[15:1]};
		c.fc    = hi[15:13];
		c.rw    = hi[9];
		if (!byte_op) begin
			// word access strobes both lanes
			c.uds_n = 1'b0;
			c.lds_n = 1'b0;
		end else if (lo[0] == 1'b0) begin
			// even byte on the upper lane
			c.uds_n = 1'b0;
			c.lds_n = 1'b1;
		end else begin
			c.uds_n = 1'b1;
			c.lds_n = 1'b0;
		end
		c.d_oe  = ~hi[9];
		c.data  = wdata;
		return c;
	endfunction

	task automatic compare_cycle();
		cycle_t exp;
		exp = expect_cycle(shadow_addr_lo, shadow_addr_hi, shadow_data);
		check_eq(32'(seen.a), 32'(exp.a), "address");
		check_eq(32'(seen.fc), 32'(exp.fc), "function code");
		check_eq(32'(seen.rw), 32'(exp.rw), "rw");
		check_eq(32'(seen.uds_n), 32'(exp.uds_n), "uds_n");
		check_eq(32'(seen.lds_n), 32'(exp.lds_n), "lds_n");
		check_eq(32'(seen.d_oe), 32'(exp.d_oe), "d_oe");
		if (exp.d_oe) begin
			check_eq(32'(seen.data), 32'(exp.data), "write data");
		end
		check_eq(32'(seen_berr), 32'(cyc_mode != MODE_BERR), "pi_berr");
		// a vpa cycle must not end before vma was given
		check_eq(32'(seen_vma), 32'(cyc_mode == MODE_VPA), "vma handshake");
		cycles_checked++;
	endtask

	always #(HALF_PERIOD) c8m = ~c8m;

	initial bus_slave();

	// counts cycle starts, compares each cycle as it ends
	always @(negedge c8m) begin
		if (s0rst) begin
			txn_q = 1'b0;
		end else begin
			if (pi_txn_in_progress && !txn_q) begin
				txn_rises++;
			end
			if (!pi_txn_in_progress && txn_q && !abort_expected) begin
				compare_cycle();
			end
			txn_q = pi_txn_in_progress;
		end
	end

	// e period of ten with four high
	always @(negedge c8m) begin
		if (s0rst) begin
			e_q          = 1'b0;
			e_period_cnt = 0;
			e_high_cnt   = 0;
			e_rises      = 0;
		end else begin
			e_period_cnt++;
			if (e) begin
				e_high_cnt++;
			end
			if (e && !e_q) begin
				if (e_rises > 0) begin
					check_eq(e_period_cnt, 32'd10, "e clock period");
				end
				e_rises++;
				e_period_cnt = 0;
			end
			if (!e && e_q) begin
				check_eq(e_high_cnt, 32'd4, "e clock high time");
				e_high_cnt = 0;
			end
			e_q = e;
		end
	end

	// vma only starts in the e low phase
	always @(negedge c8m) begin
		if (!vma_n && vma_q) begin
			check_eq(32'(e), 32'd0, "e at vma_n assertion");
		end
		vma_q = vma_n;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge c8m);
		$display("timeout: the test sequence did not finish within %0d cycles",
			WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$fatal(1, "watchdog expired");
	end

	initial begin
		pi_word_t rd;
		void'($urandom(SEED));
		c8m          = 1'b0;
		s0rst        = 1'b1;
		pi_a         = REG_DATA;
		pi_rd        = 1'b0;
		pi_wr        = 1'b0;
		pi_d_in      = '0;
		m68k_ipl_n   = 3'b111;
		m68k_reset_n = 1'b1;
		repeat (8) @(negedge c8m);
		s0rst = 1'b0;
		repeat (4) @(negedge c8m);
		check_bus_idle();
		check_eq(32'(reset_drive), 32'd0, "reset_drive after reset");
		check_eq(32'(halt_drive), 32'd0, "halt_drive after reset");
		check_eq(32'(pi_d_oe), 32'd0, "pi_d_oe after reset");

		// status after reset, then with ipl and bus reset active
		pi_read(REG_STATUS, rd);
		check_eq(32'(rd), 32'(expect_status(3'b111, 1'b1)), "status after reset");
		m68k_ipl_n   = 3'b010;
		m68k_reset_n = 1'b0;
		pi_read(REG_STATUS, rd);
		check_eq(32'(rd), 32'(expect_status(3'b010, 1'b0)), "status with ipl and reset");
		m68k_ipl_n   = 3'b111;
		m68k_reset_n = 1'b1;
		repeat (4) @(negedge c8m);

		// word writes at even addresses
		for (int i = 0; i < 4; i++) begin
			pi_write(REG_DATA, 16'($urandom));
			pi_write(REG_ADDR_LO, 16'($urandom) & 16'hfffe);
			start_cycle(addr_hi_word(8'($urandom), 1'b0, 1'b0, 3'($urandom_range(6, 1))));
		end

		// byte reads on both lanes
		for (int i = 0; i < 2; i++) begin
			pi_write(REG_ADDR_LO, (16'($urandom) & 16'hfffe) | 16'(i));
			start_cycle(addr_hi_word(8'($urandom), 1'b1, 1'b1, 3'd5));
			pi_read(REG_DATA, rd);
			check_eq(32'(rd), 32'(slave_data), "byte read data");
		end

		// bus error, then a normal read
		force_mode = MODE_BERR;
		pi_write(REG_DATA, 16'($urandom));
		pi_write(REG_ADDR_LO, 16'h2468);
		start_cycle(addr_hi_word(8'h13, 1'b0, 1'b0, 3'd1));
		force_mode = MODE_DTACK;
		pi_write(REG_ADDR_LO, 16'h0100);
		start_cycle(addr_hi_word(8'h00, 1'b0, 1'b1, 3'd6));
		pi_read(REG_DATA, rd);
		check_eq(32'(rd), 32'(slave_data), "read data after bus error");

		// synchronous peripheral cycles
		force_mode = MODE_VPA;
		pi_write(REG_DATA, 16'($urandom));
		pi_write(REG_ADDR_LO, 16'hf001);
		start_cycle(addr_hi_word(8'hbf, 1'b1, 1'b0, 3'd5));
		pi_write(REG_ADDR_LO, 16'he000);
		start_cycle(addr_hi_word(8'hbf, 1'b0, 1'b1, 3'd5));
		pi_read(REG_DATA, rd);
		check_eq(32'(rd), 32'(slave_data), "vpa read data");
		force_mode = MODE_RANDOM;

		// reset and halt drive bits
		pi_write(REG_STATUS, 16'h0003);
		check_eq(32'({reset_drive, halt_drive}), 32'(shadow_status[1:0]), "drive bits 11");
		pi_write(REG_STATUS, 16'h0002);
		check_eq(32'({reset_drive, halt_drive}), 32'(shadow_status[1:0]), "drive bits 10");
		pi_write(REG_STATUS, 16'h0000);
		check_eq(32'({reset_drive, halt_drive}), 32'(shadow_status[1:0]), "drive bits 00");

		// cycle that never terminates, cut off by the 68000 bus reset
		force_mode     = MODE_HANG;
		abort_expected = 1'b1;
		pi_write(REG_ADDR_LO, 16'h1000);
		pi_write(REG_ADDR_HI, addr_hi_word(8'h02, 1'b0, 1'b1, 3'd2));
		while (as_n) begin
			@(negedge c8m);
		end
		m68k_reset_n = 1'b0;
		while (pi_txn_in_progress) begin
			@(negedge c8m);
		end
		@(negedge c8m);
		check_bus_idle();
		m68k_reset_n = 1'b1;
		repeat (4) @(negedge c8m);
		abort_expected = 1'b0;
		force_mode     = MODE_RANDOM;

		check_eq(cycles_checked, N_COMPARED, "number of compared bus cycles");
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- src.f
+incdir+dv
logic/pistorm_pkg.sv
logic/pi_port.sv
logic/bus_cycle_fsm.sv
logic/e_clock_vma.sv
logic/m68k_bus_out.sv
logic/pistorm_bridge.sv
dv/tb_pistorm_bridge.sv

//--- Makefile
TOOL       ?= verilator
FLAGS      ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_pistorm_bridge
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   := === FAIL ===
PASS_MSG   := === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "simulation incomplete"; exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
